//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_trail_top
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TEST FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+tests
verilog/trail_pkg.sv
verilog/sprite_rom.sv
verilog/trail_classify.sv
verilog/trail_writer.sv
verilog/trail_map.sv
verilog/trail_top.sv
tests/tb_trail_top.sv

//--- tests/tb_trail_cases.svh
/*
 * move table for the trail testbench, one entry per step
 */
`ifndef TB_TRAIL_CASES_SVH
`define TB_TRAIL_CASES_SVH

localparam int NUM_STEPS = 18;

// state, blue x y dir, red x y dir, blue kind, red kind, blue crash, red crash
// every y gets the random row shift before it is driven
step_t steps [NUM_STEPS] = '{
	'{GAME_PLAY, 2, 5, DIR_RIGHT, 20, 10, DIR_LEFT, TRAIL_NONE, TRAIL_NONE, 1'b0, 1'b0},
	'{GAME_PLAY, 3, 5, DIR_RIGHT, 19, 10, DIR_LEFT, B_HORIZ, R_HORIZ, 1'b0, 1'b0},
	'{GAME_PLAY, 4, 5, DIR_RIGHT, 19, 10, DIR_LEFT, B_HORIZ, TRAIL_NONE, 1'b0, 1'b0},
	'{GAME_PLAY, 4, 5, DIR_RIGHT, 19, 9, DIR_UP, TRAIL_NONE, CORNER, 1'b0, 1'b0},
	'{GAME_PLAY, 4, 5, DIR_RIGHT, 19, 8, DIR_UP, TRAIL_NONE, R_VERT, 1'b0, 1'b0},
	'{GAME_PLAY, 4, 6, DIR_DOWN, 19, 8, DIR_UP, CORNER, TRAIL_NONE, 1'b0, 1'b0},
	'{GAME_PLAY, 4, 7, DIR_DOWN, 19, 8, DIR_UP, B_VERT, TRAIL_NONE, 1'b0, 1'b0},
	'{GAME_PLAY, 4, 8, DIR_DOWN, 19, 7, DIR_UP, B_VERT, R_VERT, 1'b0, 1'b0},
	'{GAME_PLAY, 4, 7, DIR_UP, 19, 7, DIR_UP, CORNER, TRAIL_NONE, 1'b1, 1'b0},
	'{GAME_PLAY, 4, 6, DIR_UP, 19, 6, DIR_UP, B_VERT, R_VERT, 1'b1, 1'b0},
	'{GAME_OVER, 4, 6, DIR_UP, 19, 6, DIR_UP, TRAIL_NONE, TRAIL_NONE, 1'b0, 1'b0},
	'{GAME_PLAY, 2, 5, DIR_RIGHT, 6, 5, DIR_LEFT, TRAIL_NONE, TRAIL_NONE, 1'b0, 1'b0},
	'{GAME_PLAY, 3, 5, DIR_RIGHT, 5, 5, DIR_LEFT, B_HORIZ, R_HORIZ, 1'b0, 1'b0},
	'{GAME_PLAY, 4, 5, DIR_RIGHT, 4, 5, DIR_LEFT, B_HORIZ, R_HORIZ, 1'b1, 1'b1},
	'{GAME_IDLE, 27, 12, DIR_RIGHT, 0, 14, DIR_LEFT, TRAIL_NONE, TRAIL_NONE, 1'b0, 1'b0},
	'{GAME_PLAY, 27, 12, DIR_RIGHT, 0, 14, DIR_LEFT, TRAIL_NONE, TRAIL_NONE, 1'b0, 1'b0},
	'{GAME_PLAY, 28, 12, DIR_RIGHT, 31, 14, DIR_LEFT, B_HORIZ, R_HORIZ, 1'b1, 1'b1},
	'{GAME_PLAY, 28, 12, DIR_RIGHT, 31, 14, DIR_LEFT, TRAIL_NONE, TRAIL_NONE, 1'b1, 1'b1}
};

string step_names [NUM_STEPS] = '{
	"enter_play", "both_straight", "blue_only", "red_turn_up", "red_vertical",
	"blue_turn_down", "blue_vertical", "both_vertical", "blue_hits_trail",
	"blue_crash_held", "game_over", "restart", "reuse_old_cells", "same_cell",
	"idle_reposition", "restart_at_edge", "leave_area", "flags_held"
};

`endif

//--- tests/tb_trail_top.sv
/*
 * testbench for the light-cycle trail subsystem: applies a table of player
 * moves and checks the frame-buffer writes and the crash flags
 */
`timescale 1ns/1ps

module tb_trail_top
	import trail_pkg::*;
();

	typedef struct packed {
		game_state_t state;
		int          bx;
		int          by;
		dir_t        bdir;
		int          rx;
		int          ry;
		dir_t        rdir;
		trail_kind_t bkind;
		trail_kind_t rkind;
		logic        bcrash;
		logic        rcrash;
	} step_t;

	`include "tb_trail_cases.svh"

	localparam int SETTLE_CYCLES  = 16;
	localparam int TIMEOUT_CYCLES = NUM_STEPS * 20 + 100;

	logic                 Clk;
	logic                 rst;
	game_state_t          game_state;
	logic [CELL_BITS-1:0] blue_x, blue_y, red_x, red_y;
	dir_t                 blue_dir, red_dir;
	logic [ADDR_BITS-1:0] fb_addr;
	logic [DATA_BITS-1:0] fb_data;
	logic                 fb_we;
	logic                 blue_crash, red_crash;

	logic [ADDR_BITS-1:0] cap_addr [$];
	logic [DATA_BITS-1:0] cap_data [$];
	int                   cycle_count = 0;
	int                   error_count = 0;
	int                   steps_passed = 0;
	int                   row_shift;
	int                   prev_bx, prev_by, prev_rx, prev_ry;

	trail_top i_dut (
		.Clk        (Clk),
		.rst        (rst),
		.game_state (game_state),
		.blue_x     (blue_x),
		.blue_y     (blue_y),
		.red_x      (red_x),
		.red_y      (red_y),
		.blue_dir   (blue_dir),
		.red_dir    (red_dir),
		.fb_addr    (fb_addr),
		.fb_data    (fb_data),
		.fb_we      (fb_we),
		.blue_crash (blue_crash),
		.red_crash  (red_crash)
	);

	initial
	begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;
	end

	// every frame-buffer write, in order
	always @(posedge Clk)
	begin
		if (!rst && fb_we)
		begin
			cap_addr.push_back(fb_addr);
			cap_data.push_back(fb_data);
		end
	end

	always @(posedge Clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// word j of a sprite in cell (x, y), one border cell around the grid
	function automatic logic [ADDR_BITS-1:0] frame_word_addr(input int x, input int y,
		input int j);
		return ADDR_BITS'(((y + 1) * ROW_CELLS + x + 1) * SPRITE_WORDS + j);
	endfunction

	// sprite byte k*16+j+1 spread to nibbles at bits 3:0 and 11:8
	function automatic logic [DATA_BITS-1:0] sprite_word_data(input trail_kind_t kind,
		input int j);
		int b;
		b = int'(kind) * 16 + j + 1;
		return DATA_BITS'(((b / 16) % 16) * 256 + b % 16);
	endfunction

	task automatic check_addr(input string what, input logic [ADDR_BITS-1:0] exp,
		input logic [ADDR_BITS-1:0] act);
		if (act !== exp)
		begin
			$display("Error: %s expected %h got %h", what, exp, act);
			error_count++;
		end
	endtask

	task automatic check_data(input string what, input logic [DATA_BITS-1:0] exp,
		input logic [DATA_BITS-1:0] act);
		if (act !== exp)
		begin
			$display("Error: %s expected %h got %h", what, exp, act);
			error_count++;
		end
	endtask

	task automatic check_crash(input string what, input bit exp, input logic act);
		if (act !== exp)
		begin
			$display("Error: %s expected %b got %b", what, exp, act);
			error_count++;
		end
	endtask

	task automatic drive_step(input step_t s);
		game_state <= s.state;
		blue_x     <= CELL_BITS'(s.bx);
		blue_y     <= CELL_BITS'(s.by + row_shift);
		blue_dir   <= s.bdir;
		red_x      <= CELL_BITS'(s.rx);
		red_y      <= CELL_BITS'(s.ry + row_shift);
		red_dir    <= s.rdir;
	endtask

	task automatic check_step(input int i);
		step_t                s;
		string                tag;
		int                   errors_before;
		logic [ADDR_BITS-1:0] exp_addr [$];
		logic [DATA_BITS-1:0] exp_data [$];
		s = steps[i];
		tag = $sformatf("step %0d %s", i, step_names[i]);
		errors_before = error_count;
		// blue sprite first, each at the cell that player just left
		if (s.bkind != TRAIL_NONE)
			for (int j = 0; j < SPRITE_WORDS; j++)
			begin
				exp_addr.push_back(frame_word_addr(prev_bx, prev_by, j));
				exp_data.push_back(sprite_word_data(s.bkind, j));
			end
		if (s.rkind != TRAIL_NONE)
			for (int j = 0; j < SPRITE_WORDS; j++)
			begin
				exp_addr.push_back(frame_word_addr(prev_rx, prev_ry, j));
				exp_data.push_back(sprite_word_data(s.rkind, j));
			end
		if (cap_addr.size() != exp_addr.size())
		begin
			$display("%s: expected %0d frame-buffer writes but saw %0d", tag,
				exp_addr.size(), cap_addr.size());
			error_count++;
		end
		else
			for (int j = 0; j < exp_addr.size(); j++)
			begin
				check_addr($sformatf("%s write %0d addr", tag, j), exp_addr[j], cap_addr[j]);
				check_data($sformatf("%s write %0d data", tag, j), exp_data[j], cap_data[j]);
			end
		check_crash({tag, " blue_crash"}, s.bcrash, blue_crash);
		check_crash({tag, " red_crash"}, s.rcrash, red_crash);
		cap_addr.delete();
		cap_data.delete();
		prev_bx = s.bx;
		prev_by = s.by + row_shift;
		prev_rx = s.rx;
		prev_ry = s.ry + row_shift;
		if (error_count == errors_before)
		begin
			steps_passed++;
			$display("%s: pass", tag);
		end
		else
			$display("%s: %0d errors", tag, error_count - errors_before);
	endtask

	initial
	begin
		rst        = 1'b1;
		game_state = GAME_IDLE;
		blue_x     = '0;
		blue_y     = '0;
		red_x      = '0;
		red_y      = '0;
		blue_dir   = DIR_UP;
		red_dir    = DIR_UP;
		prev_bx    = 0;
		prev_by    = 0;
		prev_rx    = 0;
		prev_ry    = 0;
		void'($urandom(41));
		// table rows stay below 20, so the shifted rows stay on the grid
		row_shift = $urandom % 9;
		$display("row shift %0d", row_shift);
		repeat (3) @(posedge Clk);
		rst <= 1'b0;
		@(posedge Clk);
		for (int i = 0; i < NUM_STEPS; i++)
		begin
			drive_step(steps[i]);
			repeat (SETTLE_CYCLES) @(posedge Clk);
			check_step(i);
		end
		$display("%0d steps, %0d passed, %0d errors", NUM_STEPS, steps_passed, error_count);
		if (error_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verilog/sprite_rom.sv
/*
 * trail sprite rom, one byte per kind and word, registered read
 */
`timescale 1ns/1ps

module sprite_rom
	import trail_pkg::*;
(
	input  logic        Clk,
	input  trail_kind_t rom_kind,
	input  logic [1:0]  rom_word,
	output logic [7:0]  rom_byte
);

	localparam int ROM_DEPTH = 8 * SPRITE_WORDS;

	logic [7:0] rom_table [ROM_DEPTH];
	logic [4:0] rom_index;

	// kind selects the sprite, word the line within it
	assign rom_index = {rom_kind, rom_word};

	// constant contents from the package rule
	for (genvar k = 0; k < 8; k++)
	begin : g_kind
		for (genvar w = 0; w < SPRITE_WORDS; w++)
		begin : g_word
			assign rom_table[k * SPRITE_WORDS + w] = sprite_byte(k, w);
		end
	end

	always_ff @(posedge Clk)
	begin
		rom_byte <= rom_table[rom_index];
	end

endmodule

//--- verilog/trail_classify.sv
/*
 * trail classifier: spots a cell change per player, picks the trail
 * sprite for the cell left behind and pulses a write request
 */
`timescale 1ns/1ps

module trail_classify
	import trail_pkg::*;
(
	input  logic                 Clk,
	input  logic                 rst,
	input  game_state_t          game_state,
	input  logic [CELL_BITS-1:0] blue_x,
	input  logic [CELL_BITS-1:0] blue_y,
	input  logic [CELL_BITS-1:0] red_x,
	input  logic [CELL_BITS-1:0] red_y,
	input  dir_t                 blue_dir,
	input  dir_t                 red_dir,
	output logic                 req,
	output logic                 mark_blue,
	output logic                 mark_red,
	output trail_kind_t          blue_kind,
	output trail_kind_t          red_kind,
	output logic [CELL_BITS-1:0] blue_cell_x,
	output logic [CELL_BITS-1:0] blue_cell_y,
	output logic [CELL_BITS-1:0] red_cell_x,
	output logic [CELL_BITS-1:0] red_cell_y,
	output logic                 blue_moved,
	output logic                 red_moved
);

	logic [CELL_BITS-1:0] prev_blue_x, prev_blue_y, prev_red_x, prev_red_y;
	dir_t                 prev_blue_dir, prev_red_dir;
	logic                 prev_play;
	logic                 in_play;
	trail_kind_t          blue_kind_next, red_kind_next;

	// turn -> corner, else straight piece in the player's colour
	function automatic trail_kind_t pick_kind(input logic moved, input dir_t dir,
		input dir_t prev_dir, input trail_kind_t horiz, input trail_kind_t vert);
		if (!moved)
			return TRAIL_NONE;
		if (dir != prev_dir)
			return CORNER;
		if (dir == DIR_UP || dir == DIR_DOWN)
			return vert;
		return horiz;
	endfunction

	assign in_play = (game_state == GAME_PLAY);

	// first sampled position after entering play is never a move
	assign blue_moved = in_play && prev_play &&
		(blue_x != prev_blue_x || blue_y != prev_blue_y);
	assign red_moved = in_play && prev_play &&
		(red_x != prev_red_x || red_y != prev_red_y);

	assign blue_kind_next = pick_kind(blue_moved, blue_dir, prev_blue_dir, B_HORIZ, B_VERT);
	assign red_kind_next  = pick_kind(red_moved, red_dir, prev_red_dir, R_HORIZ, R_VERT);

	always_ff @(posedge Clk)
	begin
		prev_blue_x   <= blue_x;
		prev_blue_y   <= blue_y;
		prev_red_x    <= red_x;
		prev_red_y    <= red_y;
		prev_blue_dir <= blue_dir;
		prev_red_dir  <= red_dir;
		// cells just left, valid with the mark pulses
		blue_cell_x   <= prev_blue_x;
		blue_cell_y   <= prev_blue_y;
		red_cell_x    <= prev_red_x;
		red_cell_y    <= prev_red_y;
	end

	always_ff @(posedge Clk)
	begin
		if (rst || !in_play)
		begin
			prev_play <= 1'b0;
			req       <= 1'b0;
			mark_blue <= 1'b0;
			mark_red  <= 1'b0;
			blue_kind <= TRAIL_NONE;
			red_kind  <= TRAIL_NONE;
		end
		else
		begin
			prev_play <= 1'b1;
			req       <= blue_moved || red_moved;
			mark_blue <= blue_moved;
			mark_red  <= red_moved;
			blue_kind <= blue_kind_next;
			red_kind  <= red_kind_next;
		end
	end

endmodule

//--- verilog/trail_map.sv
/*
 * occupancy map of the 28x28 play area with per-player crash flags
 */
`timescale 1ns/1ps

module trail_map
	import trail_pkg::*;
(
	input  logic                 Clk,
	input  logic                 rst,
	input  game_state_t          game_state,
	input  logic                 mark_blue,
	input  logic                 mark_red,
	input  logic [CELL_BITS-1:0] blue_cell_x,
	input  logic [CELL_BITS-1:0] blue_cell_y,
	input  logic [CELL_BITS-1:0] red_cell_x,
	input  logic [CELL_BITS-1:0] red_cell_y,
	input  logic                 blue_moved,
	input  logic                 red_moved,
	input  logic [CELL_BITS-1:0] blue_x,
	input  logic [CELL_BITS-1:0] blue_y,
	input  logic [CELL_BITS-1:0] red_x,
	input  logic [CELL_BITS-1:0] red_y,
	output logic                 blue_crash,
	output logic                 red_crash
);

	logic [MAP_CELLS-1:0] occupied;
	logic                 blue_hit, red_hit, same_cell;

	function automatic logic in_grid(input logic [CELL_BITS-1:0] x,
		input logic [CELL_BITS-1:0] y);
		return (int'(x) < GRID_CELLS) && (int'(y) < GRID_CELLS);
	endfunction

	function automatic logic [MAP_IDX_BITS-1:0] cell_index(input logic [CELL_BITS-1:0] x,
		input logic [CELL_BITS-1:0] y);
		return MAP_IDX_BITS'(int'(y) * GRID_CELLS + int'(x));
	endfunction

	// out of range counts as a hit, and the lookup is skipped
	assign blue_hit  = !in_grid(blue_x, blue_y) || occupied[cell_index(blue_x, blue_y)];
	assign red_hit   = !in_grid(red_x, red_y) || occupied[cell_index(red_x, red_y)];
	assign same_cell = (blue_x == red_x) && (blue_y == red_y);

	always_ff @(posedge Clk)
	begin
		if (rst || game_state != GAME_PLAY)
			occupied <= '0;
		else
		begin
			if (mark_blue && in_grid(blue_cell_x, blue_cell_y))
				occupied[cell_index(blue_cell_x, blue_cell_y)] <= 1'b1;
			if (mark_red && in_grid(red_cell_x, red_cell_y))
				occupied[cell_index(red_cell_x, red_cell_y)] <= 1'b1;
		end
	end

	// sticky until play ends
	always_ff @(posedge Clk)
	begin
		if (rst || game_state != GAME_PLAY)
		begin
			blue_crash <= 1'b0;
			red_crash  <= 1'b0;
		end
		else
		begin
			if (blue_moved && (blue_hit || same_cell))
				blue_crash <= 1'b1;
			if (red_moved && (red_hit || same_cell))
				red_crash <= 1'b1;
		end
	end

	a_blue_crash_held: assert property (@(posedge Clk) disable iff (rst)
		(game_state == GAME_PLAY && blue_crash) |=> blue_crash);

	a_red_crash_held: assert property (@(posedge Clk) disable iff (rst)
		(game_state == GAME_PLAY && red_crash) |=> red_crash);

endmodule

//--- verilog/trail_pkg.sv
/*
 * light-cycle trail subsystem: shared game, direction and trail types,
 * play-area geometry and the sprite / frame-buffer address rules
 */
package trail_pkg;

	typedef enum logic [1:0] {
		GAME_IDLE = 2'd0,
		GAME_PLAY = 2'd1,
		GAME_OVER = 2'd2
	} game_state_t;

	typedef enum logic [1:0] {
		DIR_UP    = 2'd0,
		DIR_DOWN  = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_RIGHT = 2'd3
	} dir_t;

	// also the sprite rom kind index
	typedef enum logic [2:0] {
		TRAIL_NONE = 3'd0,
		B_HORIZ    = 3'd1,
		B_VERT     = 3'd2,
		R_HORIZ    = 3'd3,
		R_VERT     = 3'd4,
		CORNER     = 3'd5
	} trail_kind_t;

	typedef enum logic [2:0] {
		W_IDLE,
		W_LOAD_B,
		W_WRITE_B,
		W_LOAD_R,
		W_WRITE_R,
		W_DONE
	} writer_state_t;

	// play area and frame buffer geometry
	localparam int GRID_CELLS   = 28;
	localparam int CELL_BITS    = 5;
	localparam int ROW_CELLS    = 30;
	localparam int SPRITE_WORDS = 4;
	localparam int ADDR_BITS    = 20;
	localparam int DATA_BITS    = 16;
	localparam int MAP_CELLS    = GRID_CELLS * GRID_CELLS;
	localparam int MAP_IDX_BITS = 10;

	// first sprite word of a cell, skipping the one-cell border
	function automatic logic [ADDR_BITS-1:0] cell_base(input logic [CELL_BITS-1:0] x,
		input logic [CELL_BITS-1:0] y);
		return ADDR_BITS'(((int'(y) + 1) * ROW_CELLS + int'(x) + 1) * SPRITE_WORDS);
	endfunction

	// stand-in sprite art, one byte per kind and word
	function automatic logic [7:0] sprite_byte(input int kind, input int word);
		return 8'(kind * 16 + word + 1);
	endfunction

endpackage

//--- verilog/trail_top.sv
/*
 * light-cycle trail subsystem: move decode, sprite copy to the frame
 * buffer and crash detection
 */
`timescale 1ns/1ps

module trail_top
	import trail_pkg::*;
(
	input  logic                 Clk,
	input  logic                 rst,
	input  game_state_t          game_state,
	input  logic [CELL_BITS-1:0] blue_x,
	input  logic [CELL_BITS-1:0] blue_y,
	input  logic [CELL_BITS-1:0] red_x,
	input  logic [CELL_BITS-1:0] red_y,
	input  dir_t                 blue_dir,
	input  dir_t                 red_dir,
	output logic [ADDR_BITS-1:0] fb_addr,
	output logic [DATA_BITS-1:0] fb_data,
	output logic                 fb_we,
	output logic                 blue_crash,
	output logic                 red_crash
);

	logic                 req, mark_blue, mark_red;
	logic                 blue_moved, red_moved;
	trail_kind_t          blue_kind, red_kind;
	logic [CELL_BITS-1:0] blue_cell_x, blue_cell_y, red_cell_x, red_cell_y;
	trail_kind_t          rom_kind;
	logic [1:0]           rom_word;
	logic [7:0]           rom_byte;

	trail_classify i_classify (
		.Clk         (Clk),
		.rst         (rst),
		.game_state  (game_state),
		.blue_x      (blue_x),
		.blue_y      (blue_y),
		.red_x       (red_x),
		.red_y       (red_y),
		.blue_dir    (blue_dir),
		.red_dir     (red_dir),
		.req         (req),
		.mark_blue   (mark_blue),
		.mark_red    (mark_red),
		.blue_kind   (blue_kind),
		.red_kind    (red_kind),
		.blue_cell_x (blue_cell_x),
		.blue_cell_y (blue_cell_y),
		.red_cell_x  (red_cell_x),
		.red_cell_y  (red_cell_y),
		.blue_moved  (blue_moved),
		.red_moved   (red_moved)
	);

	trail_writer i_writer (
		.Clk         (Clk),
		.rst         (rst),
		.game_state  (game_state),
		.req         (req),
		.blue_kind   (blue_kind),
		.red_kind    (red_kind),
		.blue_cell_x (blue_cell_x),
		.blue_cell_y (blue_cell_y),
		.red_cell_x  (red_cell_x),
		.red_cell_y  (red_cell_y),
		.rom_kind    (rom_kind),
		.rom_word    (rom_word),
		.rom_byte    (rom_byte),
		.fb_addr     (fb_addr),
		.fb_data     (fb_data),
		.fb_we       (fb_we)
	);

	sprite_rom i_rom (
		.Clk      (Clk),
		.rom_kind (rom_kind),
		.rom_word (rom_word),
		.rom_byte (rom_byte)
	);

	trail_map i_map (
		.Clk         (Clk),
		.rst         (rst),
		.game_state  (game_state),
		.mark_blue   (mark_blue),
		.mark_red    (mark_red),
		.blue_cell_x (blue_cell_x),
		.blue_cell_y (blue_cell_y),
		.red_cell_x  (red_cell_x),
		.red_cell_y  (red_cell_y),
		.blue_moved  (blue_moved),
		.red_moved   (red_moved),
		.blue_x      (blue_x),
		.blue_y      (blue_y),
		.red_x       (red_x),
		.red_y       (red_y),
		.blue_crash  (blue_crash),
		.red_crash   (red_crash)
	);

endmodule

//--- verilog/trail_writer.sv
/*
 * trail writer FSM copying the blue then the red trail sprite from the
 * sprite rom into the frame buffer one word per cycle
 */
`timescale 1ns/1ps

module trail_writer
	import trail_pkg::*;
(
	input  logic                 Clk,
	input  logic                 rst,
	input  game_state_t          game_state,
	input  logic                 req,
	input  trail_kind_t          blue_kind,
	input  trail_kind_t          red_kind,
	input  logic [CELL_BITS-1:0] blue_cell_x,
	input  logic [CELL_BITS-1:0] blue_cell_y,
	input  logic [CELL_BITS-1:0] red_cell_x,
	input  logic [CELL_BITS-1:0] red_cell_y,
	output trail_kind_t          rom_kind,
	output logic [1:0]           rom_word,
	input  logic [7:0]           rom_byte,
	output logic [ADDR_BITS-1:0] fb_addr,
	output logic [DATA_BITS-1:0] fb_data,
	output logic                 fb_we
);

	writer_state_t        state, state_next;
	trail_kind_t          blue_kind_q, red_kind_q;
	logic [CELL_BITS-1:0] blue_x_q, blue_y_q, red_x_q, red_y_q;
	logic [2:0]           word_cnt;
	logic [ADDR_BITS-1:0] addr_cnt;
	logic                 writing;
	logic                 last_word;

	assign writing = (state == W_WRITE_B) || (state == W_WRITE_R);

	// rom read pointer runs one word ahead of the write
	assign last_word = writing && (word_cnt == 3'(SPRITE_WORDS));

	always_comb
	begin
		state_next = state;
		case (state)
			W_IDLE:
				if (req)
				begin
					if (blue_kind != TRAIL_NONE)
						state_next = W_LOAD_B;
					else if (red_kind != TRAIL_NONE)
						state_next = W_LOAD_R;
					else
						state_next = W_DONE;
				end
			W_LOAD_B:
				state_next = W_WRITE_B;
			W_WRITE_B:
				if (last_word)
					state_next = (red_kind_q != TRAIL_NONE) ? W_LOAD_R : W_DONE;
			W_LOAD_R:
				state_next = W_WRITE_R;
			W_WRITE_R:
				if (last_word)
					state_next = W_DONE;
			default:
				state_next = W_IDLE;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (rst || game_state != GAME_PLAY)
			state <= W_IDLE;
		else
			state <= state_next;
	end

	// request is only taken when idle
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			blue_kind_q <= TRAIL_NONE;
			red_kind_q  <= TRAIL_NONE;
		end
		else if (state == W_IDLE && req)
		begin
			blue_kind_q <= blue_kind;
			red_kind_q  <= red_kind;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (state == W_IDLE && req)
		begin
			blue_x_q <= blue_cell_x;
			blue_y_q <= blue_cell_y;
			red_x_q  <= red_cell_x;
			red_y_q  <= red_cell_y;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (rst)
			word_cnt <= '0;
		else if (state == W_LOAD_B || state == W_LOAD_R)
			word_cnt <= word_cnt + 3'd1;
		else if (writing && !last_word)
			word_cnt <= word_cnt + 3'd1;
		else
			word_cnt <= '0;
	end

	always_ff @(posedge Clk)
	begin
		case (state)
			W_LOAD_B:
				addr_cnt <= cell_base(blue_x_q, blue_y_q);
			W_LOAD_R:
				addr_cnt <= cell_base(red_x_q, red_y_q);
			W_WRITE_B, W_WRITE_R:
				addr_cnt <= addr_cnt + 1'b1;
			default:
				addr_cnt <= addr_cnt;
		endcase
	end

	assign rom_kind = (state == W_LOAD_B || state == W_WRITE_B) ? blue_kind_q : red_kind_q;
	assign rom_word = word_cnt[1:0];

	// low nibble to bits 3:0, high nibble to bits 11:8
	assign fb_data = {4'h0, rom_byte[7:4], 4'h0, rom_byte[3:0]};
	assign fb_addr = addr_cnt;
	assign fb_we   = writing;

	// moves closer than one full write sequence get lost
	a_req_when_idle: assert property (@(posedge Clk) disable iff (rst)
		req |-> state == W_IDLE);

	// each write burst is one whole sprite
	a_we_burst: assert property (@(posedge Clk) disable iff (rst || game_state != GAME_PLAY)
		$fell(fb_we) |-> $past(fb_we, SPRITE_WORDS) && !$past(fb_we, SPRITE_WORDS + 1));

endmodule
